/* hdl/glb_pkg.sv */
// Global buffer package: data, strobe and address widths, bank count, read latency.

package glb_pkg;

    // ######################################
    // Bank word geometry
    // ######################################

    // Width of one memory word.
    localparam int BANK_DATA_WIDTH = 64;

    // One write strobe per byte of the word.
    localparam int BANK_STRB_WIDTH = BANK_DATA_WIDTH / 8;

    // Word address inside one bank, 1024 words.
    localparam int BANK_ADDR_WIDTH = 10;

    // ######################################
    // Buffer organisation
    // ######################################

    // Number of SRAM banks behind the ports.
    localparam int NUM_BANKS = 4;

    // Bank select field width.
    // Must cover NUM_BANKS.
    localparam int BANK_SEL_WIDTH = 2;

    // Full request address.
    // Bank select sits in the upper bits, word address in the lower bits.
    localparam int GLB_ADDR_WIDTH = BANK_SEL_WIDTH + BANK_ADDR_WIDTH;

    // ######################################
    // Pipeline timing
    // ######################################

    // Enabled edges from a sampled rd_en to rd_data_valid.
    // Request register, memory read register, response register.
    localparam int RD_LATENCY = 3;

endpackage

/* hdl/glb_bank_memory.sv */
// Bank memory: single-port word array with bit-masked write and registered read.

`timescale 1ns/1ps

module glb_bank_memory (
    input  logic                                clk,
    input  logic                                clk_en,
    input  logic                                arst_n,

    input  logic                                ren,
    input  logic                                wen,
    input  logic [glb_pkg::BANK_ADDR_WIDTH-1:0] addr,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] data_in,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] data_in_bit_sel,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] data_out
);

    // Number of words in the bank.
    localparam int NUM_WORDS = 2 ** glb_pkg::BANK_ADDR_WIDTH;

    // ######################################
    // Storage
    // ######################################

    // Word array.
    // Contents are undefined after reset.
    logic [glb_pkg::BANK_DATA_WIDTH-1:0] mem [NUM_WORDS];

    // Masked write.
    // Only bits with a set mask bit take the new value.
    always_ff @(posedge clk) begin
        if (clk_en && wen) begin
            mem[addr] <= (mem[addr] & ~data_in_bit_sel) | (data_in & data_in_bit_sel);
        end
    end

    // ######################################
    // Read port
    // ######################################

    // Read register.
    // Loads one enabled edge after ren, holds otherwise.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_out <= '0;
        end else if (clk_en && ren) begin
            data_out <= mem[addr];
        end
    end

endmodule

/* hdl/glb_bank_ctrl.sv */
// Bank controller: request registers, write-over-read priority, collision pulse, read response.

`timescale 1ns/1ps

module glb_bank_ctrl (
    input  logic                                clk,
    input  logic                                clk_en,
    input  logic                                arst_n,

    // Write request from the router.
    input  logic                                packet_wr_en,
    input  logic [glb_pkg::BANK_ADDR_WIDTH-1:0] packet_wr_addr,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] packet_wr_data,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] packet_wr_data_bit_sel,

    // Read request and response.
    input  logic                                packet_rd_en,
    input  logic [glb_pkg::BANK_ADDR_WIDTH-1:0] packet_rd_addr,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] packet_rd_data,
    output logic                                packet_rd_data_valid,
    output logic                                packet_rd_collision,

    // Memory port.
    output logic                                mem_rd_en,
    output logic                                mem_wr_en,
    output logic [glb_pkg::BANK_ADDR_WIDTH-1:0] mem_addr,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] mem_data_in,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] mem_data_in_bit_sel,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] mem_data_out
);

    // ######################################
    // Request register
    // ######################################

    logic                                wr_en_q;
    logic [glb_pkg::BANK_ADDR_WIDTH-1:0] wr_addr_q;
    logic [glb_pkg::BANK_DATA_WIDTH-1:0] wr_data_q;
    logic [glb_pkg::BANK_DATA_WIDTH-1:0] wr_bit_sel_q;
    logic                                rd_en_q;
    logic [glb_pkg::BANK_ADDR_WIDTH-1:0] rd_addr_q;

    // Read issued to memory, waiting for its data.
    logic                                rd_issued_q;

    // Request strobes.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_en_q <= 1'b0;
            rd_en_q <= 1'b0;
        end else if (clk_en) begin
            wr_en_q <= packet_wr_en;
            rd_en_q <= packet_rd_en;
        end
    end

    // Request payload.
    // Follows the strobes, no reset.
    always_ff @(posedge clk) begin
        if (clk_en) begin
            wr_addr_q    <= packet_wr_addr;
            wr_data_q    <= packet_wr_data;
            wr_bit_sel_q <= packet_wr_data_bit_sel;
            rd_addr_q    <= packet_rd_addr;
        end
    end

    // ######################################
    // Memory port arbitration
    // ######################################

    // Write wins the single port.
    // A read only goes out on a cycle without a write.
    assign mem_wr_en           = wr_en_q;
    assign mem_rd_en           = rd_en_q && !wr_en_q;
    assign mem_addr            = wr_en_q ? wr_addr_q : rd_addr_q;
    assign mem_data_in         = wr_data_q;
    assign mem_data_in_bit_sel = wr_bit_sel_q;

    // Dropped read.
    // Pulses while the request register holds both requests.
    assign packet_rd_collision = wr_en_q && rd_en_q;

    // ######################################
    // Read response
    // ######################################

    // Valid shift stage tracks the issued read.
    // Memory data is ready one enabled edge later.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_issued_q          <= 1'b0;
            packet_rd_data_valid <= 1'b0;
            packet_rd_data       <= '0;
        end else if (clk_en) begin
            rd_issued_q          <= mem_rd_en;
            packet_rd_data_valid <= rd_issued_q;
            if (rd_issued_q) begin
                packet_rd_data <= mem_data_out;
            end
        end
    end

endmodule

/* hdl/glb_bank.sv */
// Bank: byte strobe to bit mask expansion, bank controller and bank memory.

`timescale 1ns/1ps

module glb_bank (
    input  logic                                clk,
    input  logic                                clk_en,
    input  logic                                arst_n,

    input  logic                                wr_en,
    input  logic [glb_pkg::BANK_STRB_WIDTH-1:0] wr_strb,
    input  logic [glb_pkg::BANK_ADDR_WIDTH-1:0] wr_addr,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] wr_data,

    input  logic                                rd_en,
    input  logic [glb_pkg::BANK_ADDR_WIDTH-1:0] rd_addr,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] rd_data,
    output logic                                rd_data_valid,
    output logic                                rd_collision
);

    // Controller to memory.
    logic                                mem_rd_en;
    logic                                mem_wr_en;
    logic [glb_pkg::BANK_ADDR_WIDTH-1:0] mem_addr;
    logic [glb_pkg::BANK_DATA_WIDTH-1:0] mem_data_in;
    logic [glb_pkg::BANK_DATA_WIDTH-1:0] mem_data_in_bit_sel;
    logic [glb_pkg::BANK_DATA_WIDTH-1:0] mem_data_out;

    // Bit mask from byte strobes.
    logic [glb_pkg::BANK_DATA_WIDTH-1:0] wr_bit_sel;

    // ######################################
    // Strobe expansion
    // ######################################

    // Each strobe covers eight data bits.
    always_comb begin
        for (int i = 0; i < glb_pkg::BANK_STRB_WIDTH; i++) begin
            wr_bit_sel[i*8 +: 8] = {8{wr_strb[i]}};
        end
    end

    // ######################################
    // Controller and memory
    // ######################################

    glb_bank_ctrl i_glb_bank_ctrl (
        .clk                    (clk),
        .clk_en                 (clk_en),
        .arst_n                 (arst_n),
        .packet_wr_en           (wr_en),
        .packet_wr_addr         (wr_addr),
        .packet_wr_data         (wr_data),
        .packet_wr_data_bit_sel (wr_bit_sel),
        .packet_rd_en           (rd_en),
        .packet_rd_addr         (rd_addr),
        .packet_rd_data         (rd_data),
        .packet_rd_data_valid   (rd_data_valid),
        .packet_rd_collision    (rd_collision),
        .mem_rd_en              (mem_rd_en),
        .mem_wr_en              (mem_wr_en),
        .mem_addr               (mem_addr),
        .mem_data_in            (mem_data_in),
        .mem_data_in_bit_sel    (mem_data_in_bit_sel),
        .mem_data_out           (mem_data_out)
    );

    glb_bank_memory i_glb_bank_memory (
        .clk             (clk),
        .clk_en          (clk_en),
        .arst_n          (arst_n),
        .ren             (mem_rd_en),
        .wen             (mem_wr_en),
        .addr            (mem_addr),
        .data_in         (mem_data_in),
        .data_in_bit_sel (mem_data_in_bit_sel),
        .data_out        (mem_data_out)
    );

endmodule

/* hdl/glb_router.sv */
// Router: bank select decode for write and read requests, bank response merge.

`timescale 1ns/1ps

module glb_router (
    // Requests from the ports.
    input  logic                                wr_en,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  wr_addr,
    input  logic                                rd_en,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  rd_addr,

    // Per-bank requests.
    output logic [glb_pkg::NUM_BANKS-1:0]       bank_wr_en,
    output logic [glb_pkg::NUM_BANKS-1:0]       bank_rd_en,
    output logic [glb_pkg::BANK_ADDR_WIDTH-1:0] bank_wr_addr,
    output logic [glb_pkg::BANK_ADDR_WIDTH-1:0] bank_rd_addr,

    // Per-bank responses.
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] bank_rd_data [glb_pkg::NUM_BANKS],
    input  logic [glb_pkg::NUM_BANKS-1:0]       bank_rd_data_valid,
    input  logic [glb_pkg::NUM_BANKS-1:0]       bank_rd_collision,

    // Merged response.
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] rd_data,
    output logic                                rd_data_valid,
    output logic                                rd_collision
);

    // Bank select fields.
    logic [glb_pkg::BANK_SEL_WIDTH-1:0] wr_sel;
    logic [glb_pkg::BANK_SEL_WIDTH-1:0] rd_sel;

    // ######################################
    // Request decode
    // ######################################

    // Upper bits pick the bank.
    assign wr_sel = wr_addr[glb_pkg::GLB_ADDR_WIDTH-1 -: glb_pkg::BANK_SEL_WIDTH];
    assign rd_sel = rd_addr[glb_pkg::GLB_ADDR_WIDTH-1 -: glb_pkg::BANK_SEL_WIDTH];

    // Lower bits go to every bank.
    assign bank_wr_addr = wr_addr[glb_pkg::BANK_ADDR_WIDTH-1:0];
    assign bank_rd_addr = rd_addr[glb_pkg::BANK_ADDR_WIDTH-1:0];

    // One-hot enables.
    always_comb begin
        for (int i = 0; i < glb_pkg::NUM_BANKS; i++) begin
            bank_wr_en[i] = wr_en && (wr_sel == i[glb_pkg::BANK_SEL_WIDTH-1:0]);
            bank_rd_en[i] = rd_en && (rd_sel == i[glb_pkg::BANK_SEL_WIDTH-1:0]);
        end
    end

    // ######################################
    // Response merge
    // ######################################

    // At most one bank is valid per cycle.
    // Idle bank data is masked off by its valid bit.
    always_comb begin
        rd_data = '0;
        for (int i = 0; i < glb_pkg::NUM_BANKS; i++) begin
            if (bank_rd_data_valid[i]) begin
                rd_data = rd_data | bank_rd_data[i];
            end
        end
    end

    // Pulses simply OR together.
    assign rd_data_valid = |bank_rd_data_valid;
    assign rd_collision  = |bank_rd_collision;

endmodule

/* hdl/glb_top.sv */
// Global buffer top level: router and four bank instances.

`timescale 1ns/1ps

module glb_top (
    input  logic                                clk,
    input  logic                                clk_en,
    input  logic                                arst_n,

    // Write port.
    input  logic                                wr_en,
    input  logic [glb_pkg::BANK_STRB_WIDTH-1:0] wr_strb,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  wr_addr,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] wr_data,

    // Read port.
    input  logic                                rd_en,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  rd_addr,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] rd_data,
    output logic                                rd_data_valid,
    output logic                                rd_collision
);

    // ######################################
    // Router to bank wiring
    // ######################################

    logic [glb_pkg::NUM_BANKS-1:0]       bank_wr_en;
    logic [glb_pkg::NUM_BANKS-1:0]       bank_rd_en;
    logic [glb_pkg::BANK_ADDR_WIDTH-1:0] bank_wr_addr;
    logic [glb_pkg::BANK_ADDR_WIDTH-1:0] bank_rd_addr;
    logic [glb_pkg::BANK_DATA_WIDTH-1:0] bank_rd_data [glb_pkg::NUM_BANKS];
    logic [glb_pkg::NUM_BANKS-1:0]       bank_rd_data_valid;
    logic [glb_pkg::NUM_BANKS-1:0]       bank_rd_collision;

    // Bank select decode and response merge.
    glb_router i_glb_router (
        .wr_en              (wr_en),
        .wr_addr            (wr_addr),
        .rd_en              (rd_en),
        .rd_addr            (rd_addr),
        .bank_wr_en         (bank_wr_en),
        .bank_rd_en         (bank_rd_en),
        .bank_wr_addr       (bank_wr_addr),
        .bank_rd_addr       (bank_rd_addr),
        .bank_rd_data       (bank_rd_data),
        .bank_rd_data_valid (bank_rd_data_valid),
        .bank_rd_collision  (bank_rd_collision),
        .rd_data            (rd_data),
        .rd_data_valid      (rd_data_valid),
        .rd_collision       (rd_collision)
    );

    // ######################################
    // Banks
    // ######################################

    // Strobes and data are shared, enables are per bank.
    for (genvar i = 0; i < glb_pkg::NUM_BANKS; i++) begin : g_bank
        glb_bank i_glb_bank (
            .clk           (clk),
            .clk_en        (clk_en),
            .arst_n        (arst_n),
            .wr_en         (bank_wr_en[i]),
            .wr_strb       (wr_strb),
            .wr_addr       (bank_wr_addr),
            .wr_data       (wr_data),
            .rd_en         (bank_rd_en[i]),
            .rd_addr       (bank_rd_addr),
            .rd_data       (bank_rd_data[i]),
            .rd_data_valid (bank_rd_data_valid[i]),
            .rd_collision  (bank_rd_collision[i])
        );
    end

endmodule

/* verif/glb_assert.sv */
// Global buffer assertions: dropped reads, collision origin and read latency origin.

`timescale 1ns/1ps

module glb_assert (
    input logic clk,
    input logic clk_en,
    input logic arst_n,
    input logic rd_en,
    input logic rd_data_valid,
    input logic rd_collision
);

    // rd_en at the last RD_LATENCY enabled edges, newest in bit 0.
    logic [glb_pkg::RD_LATENCY-1:0] rd_hist;

    // rd_collision at the last RD_LATENCY-1 enabled edges, newest in bit 0.
    logic [glb_pkg::RD_LATENCY-2:0] coll_hist;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_hist   <= '0;
            coll_hist <= '0;
        end else if (clk_en) begin
            rd_hist   <= {rd_hist[glb_pkg::RD_LATENCY-2:0], rd_en};
            coll_hist <= {coll_hist[glb_pkg::RD_LATENCY-3:0], rd_collision};
        end
    end

    // ######################################
    // Response pulses
    // ######################################

    // A read is either answered or dropped.
    // The slot of a dropped read never shows a valid.
    a_dropped_read_no_valid: assert property (
        @(posedge clk) disable iff (!arst_n)
            rd_data_valid |-> !coll_hist[glb_pkg::RD_LATENCY-2]
    ) else $error("rd_data_valid for a read dropped by a collision");

    // Dropped read was sampled at the last enabled edge.
    a_collision_after_read: assert property (
        @(posedge clk) disable iff (!arst_n) rd_collision |-> rd_hist[0]
    ) else $error("rd_collision without a sampled read");

    // Data only RD_LATENCY enabled edges after a sampled read.
    a_valid_after_latency: assert property (
        @(posedge clk) disable iff (!arst_n) rd_data_valid |-> rd_hist[glb_pkg::RD_LATENCY-1]
    ) else $error("rd_data_valid without a read RD_LATENCY enabled cycles earlier");

endmodule

/* verif/glb_tb.sv */
// Global buffer testbench: clock, reset, LFSR stimulus, reference model, checks, watchdog.

`timescale 1ns/1ps

module glb_tb;

    // Clock period in ns and the cycle budget of each test.
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int N_FULL       = 32;
    localparam int N_PART       = 24;
    localparam int N_B2B        = 40;
    localparam int N_COLL       = 8;
    localparam int N_STALL      = 200;
    localparam int DRAIN_CYCLES = 16;
    localparam int RUN_CYCLES   = RESET_CYCLES + 2 * N_FULL + 2 * N_PART + N_B2B
                                  + 4 * N_COLL + N_STALL + 5 * DRAIN_CYCLES;
    localparam int WATCHDOG_NS  = RUN_CYCLES * CLK_PERIOD + 400;

    // Maximal length feedback taps for a right-shifting Galois LFSR.
    localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

    logic                                clk;
    logic                                clk_en;
    logic                                arst_n;
    logic                                wr_en;
    logic [glb_pkg::BANK_STRB_WIDTH-1:0] wr_strb;
    logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  wr_addr;
    logic [glb_pkg::BANK_DATA_WIDTH-1:0] wr_data;
    logic                                rd_en;
    logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  rd_addr;
    logic [glb_pkg::BANK_DATA_WIDTH-1:0] rd_data;
    logic                                rd_data_valid;
    logic                                rd_collision;

    // Reference memory and the addresses it holds.
    logic [glb_pkg::BANK_DATA_WIDTH-1:0] model [logic [glb_pkg::GLB_ADDR_WIDTH-1:0]];
    logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  written [$];

    // Expected responses, tagged with the enabled cycle they are due in.
    int                                  exp_due [$];
    logic [glb_pkg::BANK_DATA_WIDTH-1:0] exp_data [$];
    int                                  coll_due [$];

    logic [31:0] lfsr = 32'h5af4_9773;
    int          en_cycle;
    int          checks;
    int          errors;
    int          start_errors;
    int          tests_run;
    int          tests_failed;
    string       cur_test;

    glb_top i_glb_top (
        .clk           (clk),
        .clk_en        (clk_en),
        .arst_n        (arst_n),
        .wr_en         (wr_en),
        .wr_strb       (wr_strb),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid),
        .rd_collision  (rd_collision)
    );

    bind glb_top glb_assert i_glb_assert (
        .clk           (clk),
        .clk_en        (clk_en),
        .arst_n        (arst_n),
        .rd_en         (rd_en),
        .rd_data_valid (rd_data_valid),
        .rd_collision  (rd_collision)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ######################################
    // Random values
    // ######################################

    // One LFSR step per bit taken, first bit ends up in the MSB.
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? LFSR_POLY : 32'h0);
            v    = {v[62:0], b};
        end
        return v;
    endfunction

    function automatic int rand_below(input int n);
        logic [63:0] v;
        v = rand_bits(16);
        return int'(v[15:0]) % n;
    endfunction

    function automatic logic [glb_pkg::BANK_STRB_WIDTH-1:0] rand_strb();
        logic [63:0] v;
        v = rand_bits(glb_pkg::BANK_STRB_WIDTH);
        return v[glb_pkg::BANK_STRB_WIDTH-1:0];
    endfunction

    // Random word inside the given bank.
    function automatic logic [glb_pkg::GLB_ADDR_WIDTH-1:0] rand_addr(input int bank);
        logic [63:0]                        v;
        logic [glb_pkg::BANK_SEL_WIDTH-1:0] sel;
        v   = rand_bits(glb_pkg::BANK_ADDR_WIDTH);
        sel = bank[glb_pkg::BANK_SEL_WIDTH-1:0];
        return {sel, v[glb_pkg::BANK_ADDR_WIDTH-1:0]};
    endfunction

    // Only words the model holds are ever read.
    function automatic logic [glb_pkg::GLB_ADDR_WIDTH-1:0] pick_written();
        return written[rand_below(written.size())];
    endfunction

    // ######################################
    // Reference model
    // ######################################

    function automatic logic [glb_pkg::BANK_SEL_WIDTH-1:0] bank_of(
        input logic [glb_pkg::GLB_ADDR_WIDTH-1:0] addr
    );
        return addr[glb_pkg::GLB_ADDR_WIDTH-1 -: glb_pkg::BANK_SEL_WIDTH];
    endfunction

    // Strobed bytes come from the write, the others keep the old word.
    function automatic logic [glb_pkg::BANK_DATA_WIDTH-1:0] merge_bytes(
        input logic [glb_pkg::BANK_DATA_WIDTH-1:0] old_word,
        input logic [glb_pkg::BANK_DATA_WIDTH-1:0] new_word,
        input logic [glb_pkg::BANK_STRB_WIDTH-1:0] strb
    );
        logic [glb_pkg::BANK_DATA_WIDTH-1:0] w;
        w = old_word;
        for (int b = 0; b < glb_pkg::BANK_STRB_WIDTH; b++) begin
            if (strb[b]) begin
                w[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return w;
    endfunction

    task automatic check_data(input string what, input logic [glb_pkg::BANK_DATA_WIDTH-1:0] exp,
                              input logic [glb_pkg::BANK_DATA_WIDTH-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s %s: expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s %s: expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    // Pulses seen at an enabled edge against what is due in this cycle.
    task automatic compare_responses();
        logic exp_valid;
        logic exp_coll;
        exp_valid = (exp_due.size() != 0) && (exp_due[0] == en_cycle);
        exp_coll  = (coll_due.size() != 0) && (coll_due[0] == en_cycle);
        check_bit("rd_data_valid", exp_valid, rd_data_valid);
        check_bit("rd_collision", exp_coll, rd_collision);
        if (exp_valid) begin
            if (rd_data_valid) begin
                check_data("rd_data", exp_data[0], rd_data);
            end
            void'(exp_due.pop_front());
            void'(exp_data.pop_front());
        end
        if (exp_coll) begin
            void'(coll_due.pop_front());
        end
    endtask

    // Requests sampled at this edge. A read meeting a write in its bank is dropped.
    task automatic track_requests();
        logic [glb_pkg::BANK_DATA_WIDTH-1:0] old_word;
        if (rd_en) begin
            if (wr_en && bank_of(wr_addr) == bank_of(rd_addr)) begin
                coll_due.push_back(en_cycle + 1);
            end else begin
                exp_due.push_back(en_cycle + glb_pkg::RD_LATENCY);
                exp_data.push_back(model[rd_addr]);
            end
        end
        if (wr_en) begin
            old_word = '0;
            if (model.exists(wr_addr)) begin
                old_word = model[wr_addr];
            end else begin
                written.push_back(wr_addr);
            end
            model[wr_addr] = merge_bytes(old_word, wr_data, wr_strb);
        end
    endtask

    // Monitor. Counts enabled edges only.
    always @(posedge clk) begin
        if (arst_n && clk_en) begin
            en_cycle = en_cycle + 1;
            compare_responses();
            track_requests();
        end
    end

    // ######################################
    // Stimulus and test flow
    // ######################################

    task automatic drive(input logic en, input logic we,
                         input logic [glb_pkg::BANK_STRB_WIDTH-1:0] strb,
                         input logic [glb_pkg::GLB_ADDR_WIDTH-1:0] wa,
                         input logic [glb_pkg::BANK_DATA_WIDTH-1:0] wd,
                         input logic re, input logic [glb_pkg::GLB_ADDR_WIDTH-1:0] ra);
        @(posedge clk);
        clk_en  <= en;
        wr_en   <= we;
        wr_strb <= strb;
        wr_addr <= wa;
        wr_data <= wd;
        rd_en   <= re;
        rd_addr <= ra;
    endtask

    task automatic idle();
        drive(1'b1, 1'b0, '0, '0, '0, 1'b0, '0);
    endtask

    task automatic start_test(input string name);
        cur_test     = name;
        start_errors = errors;
    endtask

    // Lets the last request be sampled, then waits for every due response.
    task automatic end_test();
        idle();
        idle();
        while (exp_due.size() != 0 || coll_due.size() != 0) begin
            @(posedge clk);
        end
        tests_run++;
        if (errors == start_errors) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, errors - start_errors);
        end
    endtask

    initial begin
        logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  addr;
        logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  wa;
        logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  full_addrs [$];
        logic [glb_pkg::BANK_STRB_WIDTH-1:0] strb;
        logic [63:0]                         v;
        int                                  bank;
        clk_en  = 1'b1;
        arst_n  = 1'b0;
        wr_en   = 1'b0;
        wr_strb = '0;
        wr_addr = '0;
        wr_data = '0;
        rd_en   = 1'b0;
        rd_addr = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        idle();

        // Full words spread over all banks, then read back.
        start_test("full_word");
        for (int i = 0; i < N_FULL; i++) begin
            addr = rand_addr(i % glb_pkg::NUM_BANKS);
            full_addrs.push_back(addr);
            drive(1'b1, 1'b1, '1, addr, rand_bits(glb_pkg::BANK_DATA_WIDTH), 1'b0, '0);
        end
        foreach (full_addrs[i]) begin
            drive(1'b1, 1'b0, '0, '0, '0, 1'b1, full_addrs[i]);
        end
        end_test();

        // Random strobes over known words, each read right after.
        start_test("partial_write");
        for (int i = 0; i < N_PART; i++) begin
            addr = pick_written();
            drive(1'b1, 1'b1, rand_strb(), addr, rand_bits(glb_pkg::BANK_DATA_WIDTH), 1'b0, '0);
            drive(1'b1, 1'b0, '0, '0, '0, 1'b1, addr);
        end
        end_test();

        // One read per cycle, the write of the same cycle goes to another bank.
        start_test("back_to_back");
        for (int i = 0; i < N_B2B; i++) begin
            addr = pick_written();
            bank = int'(bank_of(addr)) + 1 + rand_below(glb_pkg::NUM_BANKS - 1);
            wa   = rand_addr(bank % glb_pkg::NUM_BANKS);
            drive(1'b1, 1'b1, '1, wa, rand_bits(glb_pkg::BANK_DATA_WIDTH), 1'b1, addr);
        end
        end_test();

        // Write and read of one word together, then a read of the new data.
        start_test("collision");
        for (int i = 0; i < N_COLL; i++) begin
            addr = pick_written();
            drive(1'b1, 1'b1, '1, addr, rand_bits(glb_pkg::BANK_DATA_WIDTH), 1'b1, addr);
            idle();
            drive(1'b1, 1'b0, '0, '0, '0, 1'b1, addr);
            idle();
        end
        end_test();

        // Mixed traffic with clk_en low about one cycle in four.
        start_test("clock_enable");
        for (int i = 0; i < N_STALL; i++) begin
            v = rand_bits(5);
            if (v[4]) begin
                wa   = pick_written();
                strb = rand_strb();
            end else begin
                wa   = rand_addr(rand_below(glb_pkg::NUM_BANKS));
                strb = '1;
            end
            drive(v[1:0] != 2'b00, v[2], strb, wa, rand_bits(glb_pkg::BANK_DATA_WIDTH),
                  v[3], pick_written());
        end
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog sized from the test lengths.
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* files.f */
hdl/glb_pkg.sv
hdl/glb_bank_memory.sv
hdl/glb_bank_ctrl.sv
hdl/glb_bank.sv
hdl/glb_router.sv
hdl/glb_top.sv
verif/glb_assert.sv
verif/glb_tb.sv

/* Makefile */
# Verilator build and run of the global buffer testbench.

VERILATOR ?= verilator
TOP       ?= glb_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= >>> PASS

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up in the output.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F '$(PASS_MSG)' > /dev/null

clean:
	rm -rf $(OBJ_DIR)
